// ==== list.f ====
+incdir+source
source/board_pkg.sv
source/key_debounce.sv
source/reset_pulse_gen.sv
source/csr_bank.sv
source/board_glue_top.sv
sim/board_glue_checker.sv
sim/tb_board_glue.sv

// ==== sim/tb_board_glue.sv ====
`timescale 1ns/100ps
// testbench top, clock and reset, seeded random wishbone, switch and
// key stimulus, watchdog, DUT and checker instances
`include "board_defines.svh"

module tb_board_glue import board_pkg::*; ();

  localparam int debounce_cycles = 8;
  localparam int n_led = 16;
  localparam int n_sw  = 12;
  localparam int n_key = 24;
  localparam int n_rst = 17;                    // 3 set/clear pairs, 3 retrigger, 8 random
  localparam int n_id  = 6;
  localparam int n_trans = 2 * n_led + n_sw + n_key + n_rst + 10 * n_id;
  localparam int watchdog_cycles = n_trans * 50 + `BOARD_DEBUG_PULSE;

  logic                     clk, arst_n;
  logic [`BOARD_KEY_W-1:0]  key;              // active low
  logic [`BOARD_SW_W-1:0]   sw;
  logic                     wb_cyc, wb_stb, wb_we, wb_ack;
  csr_addr_e                wb_adr;
  logic [`BOARD_DATA_W-1:0] wb_dat_w, wb_dat_r;
  logic [`BOARD_LED_W-1:0]  led;
  logic [`BOARD_STM_W-1:0]  stm_hw_events;
  logic                     cold_reset_n, warm_reset_n, debug_reset_n;
  int                       err_cnt, chk_cnt;
  int                       bus_fail;         // strobes that never saw ack
  int                       test_err0, test_chk0;
  integer                   seed;

  board_glue_top #(.debounce_cycles(debounce_cycles)) board_glue_top_inst (
    .clk (clk), .arst_n (arst_n), .key (key), .sw (sw),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_ack (wb_ack), .wb_dat_r (wb_dat_r), .led (led),
    .stm_hw_events (stm_hw_events), .cold_reset_n (cold_reset_n),
    .warm_reset_n (warm_reset_n), .debug_reset_n (debug_reset_n)
  );

  board_glue_checker #(.debounce_cycles(debounce_cycles)) checker_inst (
    .clk (clk), .arst_n (arst_n), .key (key), .sw (sw),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_ack (wb_ack), .wb_dat_r (wb_dat_r), .led (led),
    .stm_hw_events (stm_hw_events), .cold_reset_n (cold_reset_n),
    .warm_reset_n (warm_reset_n), .debug_reset_n (debug_reset_n),
    .err_cnt (err_cnt), .chk_cnt (chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                     // 50 MHz
  end

  // ====================================================================
  // helpers drive 2 ns after the edge
  // ====================================================================
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic wb_xfer(input logic we, input logic [`BOARD_ADR_W-1:0] adr,
                         input logic [31:0] dat);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = csr_addr_e'(adr);
    wb_dat_w = dat;
    do begin
      wait_cycles(1);
      waited++;
    end while (!wb_ack && waited < 4);
    if (!wb_ack) begin
      bus_fail++;
      $display("no wb_ack within 4 cycles of the strobe to address %0d", adr);
    end
    wb_cyc = 1'b0;                                // stb low for one full cycle
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wait_cycles(1);
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_cnt + bus_fail - test_err0;
    $display("test %-14s %6d checks, %0d mismatches, %s",
             name, chk_cnt - test_chk0, errs, (errs == 0) ? "ok" : "FAIL");
    test_err0 = err_cnt + bus_fail;
    test_chk0 = chk_cnt;
  endtask

  // ====================================================================
  // stimulus
  // ====================================================================
  initial begin
    int k;
    seed = 32'h32e628fb;
    arst_n = 1'b0;
    key = '1;
    sw = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = ADDR_LED;
    wb_dat_w = '0;
    bus_fail = 0;
    test_err0 = 0;
    test_chk0 = 0;
    repeat (3) @(posedge clk);
    #2 arst_n = 1'b1;
    wait_cycles(2);
    for (int i = 0; i < n_led; i++) begin         // led write then readback
      wb_xfer(1'b1, ADDR_LED, $random(seed));
      wait_cycles({$random(seed)} % 3);
      wb_xfer(1'b0, ADDR_LED, '0);
    end
    end_test("led_register");
    for (int i = 0; i < n_sw; i++) begin
      sw = $random(seed);
      wait_cycles(3 + {$random(seed)} % 3);       // past the 2-flop sync
      wb_xfer(1'b0, ADDR_SWITCH, '0);
    end
    end_test("switches");
    for (int i = 0; i < n_key; i++) begin
      k = {$random(seed)} % `BOARD_KEY_W;
      if ($random(seed) & 1) begin                // glitch of 1..7 cycles
        key[k] = ~key[k];
        wait_cycles(1 + {$random(seed)} % (debounce_cycles - 1));
        key[k] = ~key[k];
        wait_cycles(2 + debounce_cycles + 2);
      end else begin
        key = $random(seed);
        wait_cycles(2 + debounce_cycles + 1);
      end
      wb_xfer(1'b0, ADDR_KEYS, '0);
    end
    end_test("debounce");
    for (int b = 0; b < `BOARD_RST_REQ_W; b++) begin
      wb_xfer(1'b1, ADDR_RESET_REQ, 1 << b);
      wait_cycles(`BOARD_DEBUG_PULSE + 2);
      wb_xfer(1'b1, ADDR_RESET_REQ, '0);
    end
    wb_xfer(1'b1, ADDR_RESET_REQ, 3'b100);       // debug pulse then a retrigger inside it
    wait_cycles(4);
    wb_xfer(1'b1, ADDR_RESET_REQ, '0);
    wb_xfer(1'b1, ADDR_RESET_REQ, 3'b100);
    wait_cycles(`BOARD_DEBUG_PULSE + 2);
    for (int i = 0; i < 8; i++) begin
      wb_xfer(1'b1, ADDR_RESET_REQ, $random(seed));
      wait_cycles({$random(seed)} % 12);
    end
    end_test("reset_pulses");
    for (int i = 0; i < n_id; i++) begin
      for (int a = ADDR_ID; a < 8; a++) wb_xfer(1'b0, a, '0);
      for (int a = ADDR_ID; a < 8; a++) wb_xfer(1'b1, a, $random(seed));
      wb_xfer(1'b0, ADDR_LED, '0);
      wb_xfer(1'b0, ADDR_RESET_REQ, '0);
    end
    wait_cycles(`BOARD_DEBUG_PULSE + 4);         // let pulses end under check
    end_test("id_unmapped");
    $display("summary: %0d checks, %0d mismatches, %0d bus timeouts",
             chk_cnt, err_cnt, bus_fail);
    if (err_cnt == 0 && bus_fail == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // sized from the transaction count plus the longest pulse
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== sim/board_glue_checker.sv ====
`timescale 1ns/100ps
// cycle model of the board glue block and per-cycle comparison of
// every DUT output, with mismatch and check counters
`include "board_defines.svh"

module board_glue_checker import board_pkg::*; #(
  parameter int debounce_cycles = `BOARD_DEBOUNCE_CYCLES
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`BOARD_KEY_W-1:0]  key,
  input  logic [`BOARD_SW_W-1:0]   sw,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`BOARD_ADR_W-1:0]  wb_adr,
  input  logic [`BOARD_DATA_W-1:0] wb_dat_w,
  input  logic                     wb_ack,
  input  logic [`BOARD_DATA_W-1:0] wb_dat_r,
  input  logic [`BOARD_LED_W-1:0]  led,
  input  logic [`BOARD_STM_W-1:0]  stm_hw_events,
  input  logic                     cold_reset_n,
  input  logic                     warm_reset_n,
  input  logic                     debug_reset_n,
  output int                       err_cnt,
  output int                       chk_cnt
);

  localparam int settle = 2 + debounce_cycles;   // sync stages plus stable run
  localparam int pad_w  = `BOARD_STM_W - `BOARD_SW_W - `BOARD_LED_W - `BOARD_KEY_W;

  logic [`BOARD_KEY_W-1:0]     key_q;            // key seen on the previous edge
  int                          run_len [`BOARD_KEY_W];
  logic [`BOARD_KEY_W-1:0]     db_m;             // expected debounced keys
  logic [`BOARD_SW_W-1:0]      sw_d1, sw_d2;     // 2-deep switch delay
  logic [`BOARD_LED_W-1:0]     led_m;
  logic [`BOARD_RST_REQ_W-1:0] req_m, req_q_m;
  int                          low_cnt [`BOARD_RST_REQ_W];  // low cycles left
  int                          pulse_len [`BOARD_RST_REQ_W];
  logic                        ack_m;
  logic                        fresh;            // new transfer this cycle
  logic [`BOARD_DATA_W-1:0]    dat_m;

  initial begin
    pulse_len[0] = `BOARD_COLD_PULSE;
    pulse_len[1] = `BOARD_WARM_PULSE;
    pulse_len[2] = `BOARD_DEBUG_PULSE;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // ====================================================================
  // model, advanced on every edge from pre-edge values
  // ====================================================================
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_q   = '1;                                // released
      db_m    = '0;
      sw_d1   = '0;
      sw_d2   = '0;
      led_m   = '0;
      req_m   = '0;
      req_q_m = '0;
      ack_m   = 1'b0;
      dat_m   = '0;
      for (int i = 0; i < `BOARD_KEY_W; i++) run_len[i] = 0;
      for (int i = 0; i < `BOARD_RST_REQ_W; i++) low_cnt[i] = 0;
    end else begin
      // rising request starts a pulse from this edge, busy ignores it
      for (int i = 0; i < `BOARD_RST_REQ_W; i++) begin
        if (low_cnt[i] > 0) low_cnt[i]--;
        else if (req_m[i] && !req_q_m[i]) low_cnt[i] = pulse_len[i];
      end
      req_q_m = req_m;
      fresh = wb_cyc && wb_stb && !ack_m;
      if (fresh) begin
        case (wb_adr)
          ADDR_LED:       dat_m = `BOARD_DATA_W'(led_m);
          ADDR_SWITCH:    dat_m = `BOARD_DATA_W'(sw_d2);
          ADDR_KEYS:      dat_m = `BOARD_DATA_W'(db_m);
          ADDR_RESET_REQ: dat_m = `BOARD_DATA_W'(req_m);
          ADDR_ID:        dat_m = `BOARD_ID;
          default:        dat_m = '0;
        endcase
        if (wb_we && wb_adr == ADDR_LED) led_m = wb_dat_w[`BOARD_LED_W-1:0];
        if (wb_we && wb_adr == ADDR_RESET_REQ) req_m = wb_dat_w[`BOARD_RST_REQ_W-1:0];
      end
      ack_m = fresh;                                 // one cycle after strobe
      sw_d2 = sw_d1;
      sw_d1 = sw;
      // key level settles once unchanged for settle edges
      for (int i = 0; i < `BOARD_KEY_W; i++) begin
        if (key[i] != key_q[i]) run_len[i] = 1;
        else if (run_len[i] < settle) run_len[i]++;
        if (run_len[i] == settle) db_m[i] = ~key[i]; // pressed is 1
      end
      key_q = key;
    end
  end

  // ====================================================================
  // comparison mid-cycle, all DUT outputs settled
  // ====================================================================
  always @(negedge clk) begin
    if (arst_n) begin
      compare("wb_ack", ack_m, wb_ack);
      if (ack_m) compare("wb_dat_r", dat_m, wb_dat_r);
      compare("led", led_m, led);
      compare("stm_hw_events", {{pad_w{1'b0}}, sw_d2, led_m, db_m}, stm_hw_events);
      compare("cold_reset_n", low_cnt[0] == 0, cold_reset_n);
      compare("warm_reset_n", low_cnt[1] == 0, warm_reset_n);
      compare("debug_reset_n", low_cnt[2] == 0, debug_reset_n);
    end
  end

endmodule

// ==== source/board_glue_top.sv ====
`timescale 1ns/100ps
// board glue top, key debounce, wishbone register bank,
// cold/warm/debug reset pulse generators and the trace event vector
`include "board_defines.svh"

module board_glue_top import board_pkg::*; #(
  parameter int debounce_cycles = `BOARD_DEBOUNCE_CYCLES
) (
  input  logic                     clk,           // board 50 MHz
  input  logic                     arst_n,
  input  logic [`BOARD_KEY_W-1:0]  key,           // active low
  input  logic [`BOARD_SW_W-1:0]   sw,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  csr_addr_e                wb_adr,
  input  logic [`BOARD_DATA_W-1:0] wb_dat_w,
  output logic                     wb_ack,
  output logic [`BOARD_DATA_W-1:0] wb_dat_r,
  output logic [`BOARD_LED_W-1:0]  led,
  output logic [`BOARD_STM_W-1:0]  stm_hw_events,
  output logic                     cold_reset_n,
  output logic                     warm_reset_n,
  output logic                     debug_reset_n
);

  localparam int pad_w = `BOARD_STM_W - `BOARD_SW_W - `BOARD_LED_W - `BOARD_KEY_W;

  logic [`BOARD_KEY_W-1:0]     keys_db;    // pressed is 1
  logic [`BOARD_SW_W-1:0]      sw_sync;
  logic [`BOARD_RST_REQ_W-1:0] rst_req;    // [0] cold, [1] warm, [2] debug

  // zero pad, switches, leds, keys
  assign stm_hw_events = {{pad_w{1'b0}}, sw_sync, led, keys_db};

  // ==================================================================
  // instances
  // ==================================================================
  key_debounce #(
    .width   (`BOARD_KEY_W),
    .timeout (debounce_cycles)
  ) key_debounce_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .key_n   (key),
    .keys_db (keys_db)
  );

  csr_bank csr_bank_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .sw       (sw),
    .keys_db  (keys_db),
    .led      (led),
    .sw_sync  (sw_sync),
    .rst_req  (rst_req)
  );

  reset_pulse_gen #(.pulse_ext(`BOARD_COLD_PULSE)) pulse_cold_inst (
    .clk (clk), .arst_n (arst_n), .req (rst_req[0]), .pulse_n (cold_reset_n)
  );

  reset_pulse_gen #(.pulse_ext(`BOARD_WARM_PULSE)) pulse_warm_inst (
    .clk (clk), .arst_n (arst_n), .req (rst_req[1]), .pulse_n (warm_reset_n)
  );

  reset_pulse_gen #(.pulse_ext(`BOARD_DEBUG_PULSE)) pulse_debug_inst (
    .clk (clk), .arst_n (arst_n), .req (rst_req[2]), .pulse_n (debug_reset_n)
  );

endmodule

// ==== source/csr_bank.sv ====
`timescale 1ns/100ps
// wishbone classic register bank, led and reset request registers,
// switch synchronizer and readback mux
`include "board_defines.svh"

module csr_bank import board_pkg::*; (
  input  logic                        clk,
  input  logic                        arst_n,
  // wishbone classic slave
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  csr_addr_e                   wb_adr,
  input  logic [`BOARD_DATA_W-1:0]    wb_dat_w,
  output logic                        wb_ack,
  output logic [`BOARD_DATA_W-1:0]    wb_dat_r,
  // board side
  input  logic [`BOARD_SW_W-1:0]      sw,
  input  logic [`BOARD_KEY_W-1:0]     keys_db,
  output logic [`BOARD_LED_W-1:0]     led,
  output logic [`BOARD_SW_W-1:0]      sw_sync,
  output logic [`BOARD_RST_REQ_W-1:0] rst_req
);

  logic                     wb_req;     // new transfer this cycle
  logic                     wb_wr;
  logic [`BOARD_SW_W-1:0]   sw_meta;    // first switch sync stage
  logic [`BOARD_DATA_W-1:0] rd_data;

  // ==================================================================
  // bus decode
  // ==================================================================
  // ack high blocks a second hit while the host still holds stb
  assign wb_req = wb_cyc & wb_stb & ~wb_ack;
  assign wb_wr  = wb_req & wb_we;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;                 // one cycle, never stalls
    end
  end

  // ==================================================================
  // writable registers
  // ==================================================================
  // write lands on the edge that raises ack
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led     <= '0;
      rst_req <= '0;
    end else if (wb_wr) begin
      case (wb_adr)
        ADDR_LED:       led     <= wb_dat_w[`BOARD_LED_W-1:0];
        ADDR_RESET_REQ: rst_req <= wb_dat_w[`BOARD_RST_REQ_W-1:0];
        default: ;                      // read-only or unmapped, dropped
      endcase
    end
  end

  // ==================================================================
  // switch synchronizer
  // ==================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= sw;
      sw_sync <= sw_meta;               // 2 cycles to readback and events
    end
  end

  // ==================================================================
  // readback
  // ==================================================================
  always_comb begin
    case (wb_adr)
      ADDR_LED:       rd_data = `BOARD_DATA_W'(led);
      ADDR_SWITCH:    rd_data = `BOARD_DATA_W'(sw_sync);
      ADDR_KEYS:      rd_data = `BOARD_DATA_W'(keys_db);
      ADDR_RESET_REQ: rd_data = `BOARD_DATA_W'(rst_req);
      ADDR_ID:        rd_data = `BOARD_ID;
      default:        rd_data = '0;     // 5..7
    endcase
  end

  // captured with the request, valid alongside ack
  always_ff @(posedge clk) begin
    if (wb_req) begin
      wb_dat_r <= rd_data;
    end
  end

  // ack only as the single-cycle answer to a fresh strobe
  a_ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
    else $error("wb_ack without a strobe in the previous cycle");

endmodule

// ==== source/reset_pulse_gen.sv ====
`timescale 1ns/100ps
// rising-edge detector and fixed-length pulse stretcher
// for one reset request, active-low output
`include "board_defines.svh"

module reset_pulse_gen import board_pkg::*; #(
  parameter int pulse_ext = `BOARD_COLD_PULSE
) (
  input  logic clk,
  input  logic arst_n,
  input  logic req,
  output logic pulse_n
);

  localparam int cnt_w = $clog2(pulse_ext + 1);

  pulse_state_e     state;
  logic             req_q;      // request one cycle back
  logic             req_rise;
  logic [cnt_w-1:0] remain;     // low cycles left after the current one

  assign req_rise = req & ~req_q;
  assign pulse_n  = (state == PULSE_IDLE);   // low for the whole stretch

  // ==================================================================
  // edge detect
  // ==================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req;
    end
  end

  // ==================================================================
  // stretcher FSM
  // ==================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= PULSE_IDLE;
      remain <= '0;
    end else begin
      case (state)
        PULSE_IDLE: begin
          if (req_rise) begin
            state  <= PULSE_STRETCH;
            remain <= cnt_w'(pulse_ext - 1);
          end
        end
        PULSE_STRETCH: begin
          // edges in here are dropped, no retrigger
          if (remain == '0) begin
            state <= PULSE_IDLE;
          end else begin
            remain <= remain - 1'b1;
          end
        end
        default: state <= PULSE_IDLE;
      endcase
    end
  end

  // output comes back high within pulse_ext cycles of falling
  a_pulse_len: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(pulse_n) |-> ##[1:pulse_ext] pulse_n)
    else $error("pulse_n held low longer than %0d cycles", pulse_ext);

endmodule

// ==== source/key_debounce.sv ====
`timescale 1ns/100ps
// key debouncer, two-flop synchronizer and a stability counter per key
// active-low keys in, active-high debounced levels out
`include "board_defines.svh"

module key_debounce #(
  parameter int width   = `BOARD_KEY_W,
  parameter int timeout = `BOARD_DEBOUNCE_CYCLES
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [width-1:0] key_n,
  output logic [width-1:0] keys_db
);

  localparam int cnt_w = $clog2(timeout + 1);

  logic [width-1:0] key_meta;              // first sync stage, pin polarity
  logic [width-1:0] key_sync;              // second sync stage
  logic [cnt_w-1:0] stable_cnt [width];    // cycles since last change, saturates

  // ==================================================================
  // synchronizer
  // ==================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_meta <= '1;                      // released
      key_sync <= '1;
    end else begin
      key_meta <= key_n;
      key_sync <= key_meta;
    end
  end

  // ==================================================================
  // stability counters
  // ==================================================================
  // key_meta is the next synchronized value, so a mismatch
  // means key_sync changes on this edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      keys_db <= '0;
      for (int i = 0; i < width; i++) begin
        stable_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < width; i++) begin
        if (key_meta[i] != key_sync[i]) begin
          stable_cnt[i] <= '0;             // restart on any change
        end else if (stable_cnt[i] != cnt_w'(timeout)) begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
          // counter reaches timeout on this edge, take the settled level
          if (stable_cnt[i] == cnt_w'(timeout - 1)) begin
            keys_db[i] <= ~key_sync[i];    // pressed is 1
          end
        end
      end
    end
  end

  // debounced level only moves together with a full count
  for (genvar g = 0; g < width; g++) begin : g_db_chk
    a_db_at_timeout: assert property (@(posedge clk) disable iff (!arst_n)
      $changed(keys_db[g]) |-> stable_cnt[g] == cnt_w'(timeout))
      else $error("keys_db[%0d] changed before its counter hit the timeout", g);
  end

endmodule

// ==== source/board_pkg.sv ====
// register map and pulse stretcher state types
`include "board_defines.svh"

package board_pkg;

  // ==================================================================
  // wishbone register word addresses
  // ==================================================================
  typedef enum logic [`BOARD_ADR_W-1:0] {
    ADDR_LED       = 0,  // r/w, low 10 bits
    ADDR_SWITCH    = 1,  // ro, synchronized switches
    ADDR_KEYS      = 2,  // ro, debounced keys, pressed is 1
    ADDR_RESET_REQ = 3,  // r/w, request levels
    ADDR_ID        = 4   // ro, fixed word
  } csr_addr_e;
  // 5..7 unmapped, read as zero

  // ==================================================================
  // reset pulse stretcher
  // ==================================================================
  typedef enum logic {
    PULSE_IDLE,     // output high, watching for a rising request
    PULSE_STRETCH   // output held low, new edges dropped
  } pulse_state_e;

endpackage

// ==== source/board_defines.svh ====
// board glue widths, reset pulse lengths, debounce timeout
// and the fixed identification word
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ====================================================================
// bus and port widths
// ====================================================================
`define BOARD_DATA_W          32      // wishbone data
`define BOARD_ADR_W           3       // wishbone word address
`define BOARD_KEY_W           4       // push keys, active low on the pins
`define BOARD_SW_W            10      // slide switches
`define BOARD_LED_W           10      // red leds
`define BOARD_STM_W           28      // trace event vector
`define BOARD_RST_REQ_W       3       // cold, warm, debug

// ====================================================================
// reset request pulse lengths, in clk cycles
// ====================================================================
`define BOARD_COLD_PULSE      6
`define BOARD_WARM_PULSE      2
`define BOARD_DEBUG_PULSE     32

// 1 ms at 50 MHz
`define BOARD_DEBOUNCE_CYCLES 50000

// readback at ADDR_ID
`define BOARD_ID              32'h6b1e_0a01

`endif
